//--- all.f
rtl/a800_io_pkg.sv
rtl/disk_host_regs.sv
rtl/drive_request.sv
rtl/sector_xfer.sv
rtl/mouse_axis.sv
rtl/a800_io_top.sv
verif/a800_io_sva.sv
verif/tb_a800_io.sv

//--- rtl/a800_io_pkg.sv
package a800_io_pkg;

	// ====================
	// Sizes
	// ====================
	localparam int NUM_SLOTS = 4;
	localparam int SLOT_W    = $clog2(NUM_SLOTS);
	localparam int LBA_W     = 32;

	// ====================
	// Disk mailbox
	// ====================

	// Control word from the drive emulation with lba_sel in bit 0
	typedef struct packed {
		logic [2:0] drv_num;
		logic       block_wr;
		logic       block_rd;
		logic       lba_sel;
	} disk_ctrl_t;

	// Status byte polled by the host disk routine
	typedef struct packed {
		logic       readonly;
		logic [1:0] filetype;
		logic [2:0] fileno;
		logic       mounted;
		logic       io_done;
	} disk_status_t;

	// Host data word read as a sector number or as a single byte
	typedef union packed {
		logic [LBA_W-1:0] lba;
		struct packed {
			logic [LBA_W-9:0] unused;
			logic [7:0]       data;
		} bv;
	} host_word_u;

	// ====================
	// Mouse
	// ====================

	// PS/2 style movement packet with toggling strobe on top
	typedef struct packed {
		logic       strobe;
		logic [7:0] dy;
		logic [7:0] dx;
		logic [1:0] ovf;
		logic       y_sign;
		logic       x_sign;
		logic [1:0] misc;
		logic [1:0] btn;
	} mouse_pkt_t;

	typedef logic signed [8:0] axis_t;

endpackage

//--- rtl/a800_io_top.sv
module a800_io_top #(
	parameter int SECTOR_AW = 9,
	parameter int STEP_MAX  = 10
) (
	input  logic                              clk_sys,
	input  logic                              areset,
	// Host mailbox
	input  a800_io_pkg::disk_ctrl_t           ctrl_i,
	input  a800_io_pkg::host_word_u           wdata_i,
	input  logic                              data_wr_i,
	input  logic                              data_rd_i,
	input  logic                              io_wr_i,
	output a800_io_pkg::disk_status_t         status_o,
	output logic [a800_io_pkg::LBA_W-1:0]     rdata_o,
	// SD sector service
	output logic [a800_io_pkg::LBA_W-1:0]     sd_lba_o,
	output logic [a800_io_pkg::NUM_SLOTS-1:0] sd_rd_o,
	output logic [a800_io_pkg::NUM_SLOTS-1:0] sd_wr_o,
	input  logic [a800_io_pkg::NUM_SLOTS-1:0] sd_ack_i,
	input  logic [SECTOR_AW-1:0]              sd_addr_i,
	input  logic [7:0]                        sd_wdata_i,
	input  logic                              sd_we_i,
	output logic [7:0]                        sd_rdata_o,
	// Image mounts
	input  logic [a800_io_pkg::NUM_SLOTS-1:0] img_mounted_i,
	input  logic                              img_readonly_i,
	input  logic [1:0]                        img_type_i,
	input  logic [63:0]                       img_size_i,
	// Mouse and analog stick
	input  a800_io_pkg::mouse_pkt_t           mouse_i,
	input  logic [15:0]                       analog_i,
	input  logic [13:0]                       joy_i,
	input  logic                              halt_i,
	input  logic                              invert_y_i,
	output logic [7:0]                        paddle_x_o,
	output logic [7:0]                        paddle_y_o,
	output logic [13:0]                       joy_o
);

	logic        req_start;
	logic        ack_done;
	logic [31:0] img_size;

	disk_host_regs i_host_regs (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.img_type_i     (img_type_i),
		.img_size_i     (img_size_i),
		.req_start_i    (req_start),
		.ack_done_i     (ack_done),
		.status_o       (status_o),
		.img_size_o     (img_size)
	);

	drive_request i_drive_req (
		.clk_sys     (clk_sys),
		.areset      (areset),
		.ctrl_i      (ctrl_i),
		.sd_ack_i    (sd_ack_i),
		.sd_rd_o     (sd_rd_o),
		.sd_wr_o     (sd_wr_o),
		.req_start_o (req_start),
		.ack_done_o  (ack_done)
	);

	sector_xfer #(
		.SECTOR_AW (SECTOR_AW)
	) i_sector_xfer (
		.clk_sys    (clk_sys),
		.areset     (areset),
		.ctrl_i     (ctrl_i),
		.wdata_i    (wdata_i),
		.data_wr_i  (data_wr_i),
		.data_rd_i  (data_rd_i),
		.io_wr_i    (io_wr_i),
		.img_size_i (img_size),
		.sd_addr_i  (sd_addr_i),
		.sd_wdata_i (sd_wdata_i),
		.sd_we_i    (sd_we_i),
		.rdata_o    (rdata_o),
		.sd_lba_o   (sd_lba_o),
		.sd_rdata_o (sd_rdata_o)
	);

	mouse_axis #(
		.STEP_MAX (STEP_MAX)
	) i_mouse_axis (
		.clk_sys    (clk_sys),
		.areset     (areset),
		.mouse_i    (mouse_i),
		.analog_i   (analog_i),
		.joy_i      (joy_i),
		.halt_i     (halt_i),
		.invert_y_i (invert_y_i),
		.paddle_x_o (paddle_x_o),
		.paddle_y_o (paddle_y_o),
		.joy_o      (joy_o)
	);

endmodule

//--- rtl/disk_host_regs.sv
module disk_host_regs (
	input  logic                              clk_sys,
	input  logic                              areset,
	input  logic [a800_io_pkg::NUM_SLOTS-1:0] img_mounted_i,
	input  logic                              img_readonly_i,
	input  logic [1:0]                        img_type_i,
	input  logic [63:0]                       img_size_i,
	input  logic                              req_start_i,
	input  logic                              ack_done_i,
	output a800_io_pkg::disk_status_t         status_o,
	output logic [a800_io_pkg::LBA_W-1:0]     img_size_o
);

	logic       mnt_any;
	logic       mnt_q;
	logic       mnt_rise;
	logic [2:0] mnt_fileno;
	logic       io_done_q;
	logic       mounted_q;
	logic [2:0] fileno_q;
	logic [1:0] filetype_q;
	logic       readonly_q;

	assign mnt_any  = |img_mounted_i;
	assign mnt_rise = mnt_any & ~mnt_q;

	// Slots 2 and 3 land on files 4 and 5 and the highest slot wins
	always_comb begin
		mnt_fileno = 3'd0;
		if (img_mounted_i[1])
			mnt_fileno = 3'd1;
		if (img_mounted_i[2])
			mnt_fileno = 3'd4;
		if (img_mounted_i[3])
			mnt_fileno = 3'd5;
	end

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			mnt_q     <= 1'b0;
			io_done_q <= 1'b0;
			mounted_q <= 1'b0;
		end else begin
			mnt_q <= mnt_any;
			if (req_start_i)
				io_done_q <= 1'b0;
			// Completion of the acknowledge takes priority
			if (ack_done_i)
				io_done_q <= 1'b1;
			if (mnt_rise)
				mounted_q <= ~mounted_q;
		end
	end

	// Mount details are only meaningful once mounted has toggled
	always_ff @(posedge clk_sys) begin
		if (mnt_rise) begin
			fileno_q   <= mnt_fileno;
			filetype_q <= img_type_i;
			readonly_q <= img_readonly_i | img_mounted_i[2] | img_mounted_i[3];
			img_size_o <= img_size_i[31:0];
		end
	end

	assign status_o = '{readonly: readonly_q, filetype: filetype_q, fileno: fileno_q,
		mounted: mounted_q, io_done: io_done_q};

endmodule

//--- rtl/drive_request.sv
module drive_request (
	input  logic                              clk_sys,
	input  logic                              areset,
	input  a800_io_pkg::disk_ctrl_t           ctrl_i,
	input  logic [a800_io_pkg::NUM_SLOTS-1:0] sd_ack_i,
	output logic [a800_io_pkg::NUM_SLOTS-1:0] sd_rd_o,
	output logic [a800_io_pkg::NUM_SLOTS-1:0] sd_wr_o,
	output logic                              req_start_o,
	output logic                              ack_done_o
);

	import a800_io_pkg::*;

	logic              rd_lvl_q;
	logic              wr_lvl_q;
	logic              ack_q;
	logic              rd_rise;
	logic              wr_rise;
	logic              ack_any;
	logic [SLOT_W-1:0] slot;

	// Drive bits 2 and 0 pick the slot while bit 1 is ignored
	assign slot = {ctrl_i.drv_num[2], ctrl_i.drv_num[0]};

	assign rd_rise = ctrl_i.block_rd & ~rd_lvl_q;
	assign wr_rise = ctrl_i.block_wr & ~wr_lvl_q;
	assign ack_any = |sd_ack_i;

	assign req_start_o = rd_rise | wr_rise;
	assign ack_done_o  = ack_q & ~ack_any;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			rd_lvl_q <= 1'b0;
			wr_lvl_q <= 1'b0;
			ack_q    <= 1'b0;
			sd_rd_o  <= '0;
			sd_wr_o  <= '0;
		end else begin
			rd_lvl_q <= ctrl_i.block_rd;
			wr_lvl_q <= ctrl_i.block_wr;
			ack_q    <= ack_any;
			if (ack_any) begin
				// Any acknowledge drops every pending request
				sd_rd_o <= '0;
				sd_wr_o <= '0;
			end else begin
				if (rd_rise)
					sd_rd_o[slot] <= 1'b1;
				if (wr_rise)
					sd_wr_o[slot] <= 1'b1;
			end
		end
	end

endmodule

//--- rtl/mouse_axis.sv
module mouse_axis #(
	parameter int STEP_MAX = 10
) (
	input  logic                    clk_sys,
	input  logic                    areset,
	input  a800_io_pkg::mouse_pkt_t mouse_i,
	input  logic [15:0]             analog_i,
	input  logic [13:0]             joy_i,
	input  logic                    halt_i,
	input  logic                    invert_y_i,
	output logic [7:0]              paddle_x_o,
	output logic [7:0]              paddle_y_o,
	output logic [13:0]             joy_o
);

	import a800_io_pkg::*;

	axis_t mx;
	axis_t my;
	axis_t dx_lim;
	axis_t dy_lim;
	axis_t next_x;
	axis_t next_y;
	logic  stb_q;
	logic  emu_q;
	logic  takeover;

	function automatic axis_t limit_step(input axis_t d);
		axis_t lim;
		lim = axis_t'(STEP_MAX);
		if (d > lim)
			return lim;
		else if (d < -lim)
			return -lim;
		return d;
	endfunction

	function automatic axis_t saturate(input axis_t s);
		if (s < -9'sd128)
			return -9'sd128;
		else if (s > 9'sd127)
			return 9'sd127;
		return s;
	endfunction

	assign dx_lim = limit_step({mouse_i.x_sign, mouse_i.dx});
	assign dy_lim = limit_step({mouse_i.y_sign, mouse_i.dy});
	assign next_x = mx + dx_lim;
	assign next_y = invert_y_i ? my - dy_lim : my + dy_lim;

	// Real stick movement or a halted CPU hands control back
	assign takeover = (analog_i != 16'd0) | halt_i;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			stb_q <= mouse_i.strobe;
			emu_q <= 1'b0;
			mx    <= '0;
			my    <= '0;
		end else begin
			stb_q <= mouse_i.strobe;
			if (takeover) begin
				emu_q <= 1'b0;
				mx    <= '0;
				my    <= '0;
			end else if (stb_q != mouse_i.strobe) begin
				emu_q <= 1'b1;
				mx    <= saturate(next_x);
				my    <= saturate(next_y);
			end
		end
	end

	assign paddle_x_o = emu_q ? mx[7:0] : analog_i[7:0];
	assign paddle_y_o = emu_q ? my[7:0] : analog_i[15:8];
	assign joy_o      = {joy_i[13:9], emu_q ? mouse_i.btn : joy_i[8:7], joy_i[6:0]};

endmodule

//--- rtl/sector_xfer.sv
module sector_xfer #(
	parameter int SECTOR_AW = 9
) (
	input  logic                          clk_sys,
	input  logic                          areset,
	input  a800_io_pkg::disk_ctrl_t       ctrl_i,
	input  a800_io_pkg::host_word_u       wdata_i,
	input  logic                          data_wr_i,
	input  logic                          data_rd_i,
	input  logic                          io_wr_i,
	input  logic [a800_io_pkg::LBA_W-1:0] img_size_i,
	input  logic [SECTOR_AW-1:0]          sd_addr_i,
	input  logic [7:0]                    sd_wdata_i,
	input  logic                          sd_we_i,
	output logic [a800_io_pkg::LBA_W-1:0] rdata_o,
	output logic [a800_io_pkg::LBA_W-1:0] sd_lba_o,
	output logic [7:0]                    sd_rdata_o
);

	logic [7:0]           mem [0:(1<<SECTOR_AW)-1];
	logic [SECTOR_AW-1:0] ptr;
	logic                 wr_q1;
	logic                 wr_q2;
	logic                 rd_q;
	logic                 wr_step;
	logic [7:0]           host_q;
	logic                 wr_fire;

	// Write strobe acts on the second cycle after it rises
	assign wr_fire = wr_q1 & ~wr_q2;

	// ====================
	// Host pointer
	// ====================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			wr_q1   <= 1'b0;
			wr_q2   <= 1'b0;
			rd_q    <= 1'b0;
			wr_step <= 1'b0;
			ptr     <= '0;
		end else begin
			wr_q1   <= data_wr_i;
			wr_q2   <= wr_q1;
			rd_q    <= data_rd_i;
			wr_step <= wr_fire & ~ctrl_i.lba_sel;
			if (wr_step)
				ptr <= ptr + 1'b1;
			// Advance once the host has finished its read access
			if (rd_q && !data_rd_i)
				ptr <= ptr + 1'b1;
			if (io_wr_i)
				ptr <= '0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_fire && ctrl_i.lba_sel)
			sd_lba_o <= wdata_i.lba;
	end

	// ====================
	// Sector buffer
	// ====================
	always_ff @(posedge clk_sys) begin
		if (sd_we_i)
			mem[sd_addr_i] <= sd_wdata_i;
		if (wr_fire && !ctrl_i.lba_sel)
			mem[ptr] <= wdata_i.bv.data;
		sd_rdata_o <= mem[sd_addr_i];
		host_q     <= mem[ptr];
	end

	// Size of the last mount when lba_sel is up and otherwise the current byte
	assign rdata_o = ctrl_i.lba_sel ? img_size_i : {24'd0, host_q};

endmodule

//--- run.sh
#!/bin/sh
# Compile the RTL and testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_a800_io -f all.f -o tb_a800_io
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_a800_io)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "NO ERRORS"; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1

//--- verif/a800_io_input.txt
// Columns: op arg1 arg2 expected, all hex, op 0 ends the list
// op 1 mount, 2 sector number, 3 buffer, 4 request, 5 mouse (arg2 packets), 6 analog
01 00000001 00001234 00000008
01 00000112 0002D000 00000031
01 00000200 00016800 00000024
01 00000303 DEADBEEF 0000003D
02 00000168 00000000 00000168
02 CAFE0042 00000000 CAFE0042
03 00000008 00000000 00000000
04 00000000 00000000 00000001
04 00000011 00000000 00000002
04 00000004 00000000 00000004
04 00000015 00000000 00000008
04 00000002 00000000 00000001
04 00000017 00000000 00000008
05 01003005 00000001 00010305
05 021CE064 00000001 0002F90F
05 130081FD 00000001 0003F10C
05 0018007F 00000014 0000807F
05 111801FB 00000001 00018A7A
06 00004C23 00000000 00004C23
05 00001002 00000001 00000102
00 00000000 00000000 00000000

//--- verif/a800_io_sva.sv
module a800_io_sva (
	input logic                              clk_sys,
	input logic                              areset,
	input logic [a800_io_pkg::NUM_SLOTS-1:0] sd_rd_i,
	input logic [a800_io_pkg::NUM_SLOTS-1:0] sd_wr_i,
	input logic [a800_io_pkg::NUM_SLOTS-1:0] sd_ack_i
);

	// At most one pending request across both directions
	a_one_request: assert property (@(posedge clk_sys) disable iff (areset)
		$onehot0({sd_rd_i, sd_wr_i}))
		else $error("More than one request line set");

	// Lines come out of reset clear
	a_reset_clear: assert property (@(posedge clk_sys)
		areset |=> (sd_rd_i == '0 && sd_wr_i == '0))
		else $error("Request line set in the cycle after reset");

	a_ack_clear: assert property (@(posedge clk_sys) disable iff (areset)
		(|sd_ack_i) |=> (sd_rd_i == '0 && sd_wr_i == '0))
		else $error("Request line still set after acknowledge");

endmodule

bind drive_request a800_io_sva i_sva (
	.clk_sys  (clk_sys),
	.areset   (areset),
	.sd_rd_i  (sd_rd_o),
	.sd_wr_i  (sd_wr_o),
	.sd_ack_i (sd_ack_i)
);

//--- verif/tb_a800_io.sv
module tb_a800_io;

	import a800_io_pkg::*;

	localparam int MAX_REC = 64;

	logic                 clk_sys = 1'b0;
	logic                 areset;
	disk_ctrl_t           ctrl_i;
	host_word_u           wdata_i;
	logic                 data_wr_i;
	logic                 data_rd_i;
	logic                 io_wr_i;
	disk_status_t         status_o;
	logic [31:0]          rdata_o;
	logic [31:0]          sd_lba_o;
	logic [NUM_SLOTS-1:0] sd_rd_o;
	logic [NUM_SLOTS-1:0] sd_wr_o;
	logic [NUM_SLOTS-1:0] sd_ack_i;
	logic [8:0]           sd_addr_i;
	logic [7:0]           sd_wdata_i;
	logic                 sd_we_i;
	logic [7:0]           sd_rdata_o;
	logic [NUM_SLOTS-1:0] img_mounted_i;
	logic                 img_readonly_i;
	logic [1:0]           img_type_i;
	logic [63:0]          img_size_i;
	mouse_pkt_t           mouse_i;
	logic [15:0]          analog_i;
	logic [13:0]          joy_i;
	logic                 halt_i;
	logic                 invert_y_i;
	logic [7:0]           paddle_x_o;
	logic [7:0]           paddle_y_o;
	logic [13:0]          joy_o;

	logic [31:0] rec_mem [0:4*MAX_REC-1];
	logic        mounted_exp;
	int          cycle_cnt = 0;
	int          cycle_limit = 0;

	a800_io_top #(
		.SECTOR_AW (9),
		.STEP_MAX  (10)
	) i_dut (.*);

	always #50 clk_sys = ~clk_sys;

	// ====================
	// Helpers
	// ====================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		if (act_v !== exp_v)
			abort_run($sformatf("[ERROR] %s expected %h actual %h", name, exp_v, act_v));
	endtask

	// Lets n edges pass and returns at the following falling edge
	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
			abort_run($sformatf("Timeout: run still busy after %0d cycles", cycle_cnt));
	end

	task automatic clear_pointer();
		@(posedge clk_sys);
		ctrl_i.lba_sel <= 1'b0;
		io_wr_i        <= 1'b1;
		@(posedge clk_sys);
		io_wr_i <= 1'b0;
		idle_cycles(4);
	endtask

	task automatic write_host_byte(input logic [7:0] b);
		@(posedge clk_sys);
		wdata_i.bv.data <= b;
		data_wr_i       <= 1'b1;
		@(posedge clk_sys);
		data_wr_i <= 1'b0;
		idle_cycles(4);
	endtask

	// Checks the byte at the pointer and steps past it
	task automatic read_host_byte(input string name, input logic [7:0] exp_b);
		check_value(name, {24'd0, exp_b}, rdata_o);
		@(posedge clk_sys);
		data_rd_i <= 1'b1;
		@(posedge clk_sys);
		data_rd_i <= 1'b0;
		idle_cycles(4);
	endtask

	// ====================
	// Operations
	// ====================
	task automatic mount_image(input logic [31:0] arg1, input logic [31:0] arg2,
		input logic [31:0] exp_v);
		@(posedge clk_sys);
		img_mounted_i  <= 4'b0001 << arg1[9:8];
		img_readonly_i <= arg1[4];
		img_type_i     <= arg1[1:0];
		img_size_i     <= {~arg2, arg2};
		ctrl_i.lba_sel <= 1'b1;
		@(posedge clk_sys);
		img_mounted_i <= '0;
		idle_cycles(4);
		mounted_exp = ~mounted_exp;
		check_value("mount_info", exp_v,
			{26'd0, status_o.readonly, status_o.filetype, status_o.fileno});
		check_value("mount_toggle", {31'd0, mounted_exp}, {31'd0, status_o.mounted});
		check_value("mount_size", arg2, rdata_o);
	endtask

	task automatic latch_sector_number(input logic [31:0] arg1, input logic [31:0] exp_v);
		@(posedge clk_sys);
		ctrl_i.lba_sel <= 1'b1;
		wdata_i.lba    <= arg1;
		data_wr_i      <= 1'b1;
		@(posedge clk_sys);
		data_wr_i <= 1'b0;
		idle_cycles(4);
		check_value("sector_number", exp_v, sd_lba_o);
	endtask

	task automatic exercise_buffer(input int count);
		logic [7:0] host_bytes [$];
		logic [7:0] sd_bytes [$];
		logic [7:0] b;
		int         i;
		clear_pointer();
		for (i = 0; i < count; i++) begin
			b = 8'($urandom);
			host_bytes.push_back(b);
			write_host_byte(b);
		end
		clear_pointer();
		for (i = 0; i < count; i++)
			read_host_byte("buffer_host_read", host_bytes[i]);
		// Same bytes seen from the SD port
		for (i = 0; i < count; i++) begin
			@(posedge clk_sys);
			sd_addr_i <= 9'(i);
			idle_cycles(2);
			check_value("buffer_sd_read", {24'd0, host_bytes[i]}, {24'd0, sd_rdata_o});
		end
		for (i = 0; i < count; i++) begin
			b = 8'($urandom);
			sd_bytes.push_back(b);
			@(posedge clk_sys);
			sd_addr_i  <= 9'(i);
			sd_wdata_i <= b;
			sd_we_i    <= 1'b1;
		end
		@(posedge clk_sys);
		sd_we_i <= 1'b0;
		clear_pointer();
		for (i = 0; i < count; i++)
			read_host_byte("sd_to_host_read", sd_bytes[i]);
	endtask

	task automatic issue_request(input logic [31:0] arg1, input logic [31:0] exp_v);
		logic [3:0] hit;
		logic [3:0] other;
		@(posedge clk_sys);
		ctrl_i.drv_num <= arg1[2:0];
		if (arg1[4])
			ctrl_i.block_wr <= 1'b1;
		else
			ctrl_i.block_rd <= 1'b1;
		idle_cycles(4);
		hit   = arg1[4] ? sd_wr_o : sd_rd_o;
		other = arg1[4] ? sd_rd_o : sd_wr_o;
		check_value("request_line", exp_v, {28'd0, hit});
		check_value("request_other", 32'd0, {28'd0, other});
		check_value("io_done_cleared", 32'd0, {31'd0, status_o.io_done});
		// SD service acknowledges the line it serves
		@(posedge clk_sys);
		ctrl_i.block_rd <= 1'b0;
		ctrl_i.block_wr <= 1'b0;
		sd_ack_i        <= exp_v[3:0];
		@(posedge clk_sys);
		sd_ack_i <= '0;
		idle_cycles(4);
		check_value("request_after_ack", 32'd0, {24'd0, sd_rd_o, sd_wr_o});
		check_value("io_done_set", 32'd1, {31'd0, status_o.io_done});
	endtask

	task automatic send_mouse_packets(input logic [31:0] arg1, input logic [31:0] arg2,
		input logic [31:0] exp_v);
		int k;
		for (k = 0; k < int'(arg2); k++) begin
			@(posedge clk_sys);
			mouse_i.dx     <= arg1[7:0];
			mouse_i.x_sign <= arg1[8];
			mouse_i.dy     <= arg1[19:12];
			mouse_i.y_sign <= arg1[20];
			mouse_i.btn    <= arg1[25:24];
			mouse_i.strobe <= ~mouse_i.strobe;
			invert_y_i     <= arg1[28];
			idle_cycles(4);
		end
		check_value("paddle_x", {24'd0, exp_v[7:0]}, {24'd0, paddle_x_o});
		check_value("paddle_y", {24'd0, exp_v[15:8]}, {24'd0, paddle_y_o});
		check_value("mouse_buttons", {30'd0, exp_v[17:16]}, {30'd0, joy_o[8:7]});
		check_value("joy_passthrough", {20'd0, joy_i[13:9], joy_i[6:0]},
			{20'd0, joy_o[13:9], joy_o[6:0]});
	endtask

	task automatic apply_analog(input logic [31:0] arg1, input logic [31:0] exp_v);
		@(posedge clk_sys);
		analog_i <= arg1[15:0];
		idle_cycles(4);
		check_value("analog_paddles", exp_v, {16'd0, paddle_y_o, paddle_x_o});
		check_value("analog_joy", {18'd0, joy_i}, {18'd0, joy_o});
		@(posedge clk_sys);
		analog_i <= '0;
		idle_cycles(4);
		check_value("axes_released", 32'd0, {16'd0, paddle_y_o, paddle_x_o});
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		int          n_rec;
		int          r;
		logic [31:0] arg1;
		logic [31:0] arg2;
		logic [31:0] exp_v;
		areset         <= 1'b1;
		ctrl_i         <= '0;
		wdata_i        <= '0;
		data_wr_i      <= 1'b0;
		data_rd_i      <= 1'b0;
		io_wr_i        <= 1'b0;
		sd_ack_i       <= '0;
		sd_addr_i      <= '0;
		sd_wdata_i     <= '0;
		sd_we_i        <= 1'b0;
		img_mounted_i  <= '0;
		img_readonly_i <= 1'b0;
		img_type_i     <= '0;
		img_size_i     <= '0;
		mouse_i        <= '0;
		analog_i       <= '0;
		joy_i          <= 14'h1A5C;
		halt_i         <= 1'b0;
		invert_y_i     <= 1'b0;
		mounted_exp = 1'b0;
		void'($urandom(5));
		for (r = 0; r < 4 * MAX_REC; r++)
			rec_mem[r] = '0;
		$readmemh("verif/a800_io_input.txt", rec_mem);
		n_rec = 0;
		while (n_rec < MAX_REC && rec_mem[4*n_rec] != 32'd0)
			n_rec++;
		if (n_rec == 0)
			abort_run("No stimulus records found in verif/a800_io_input.txt");
		cycle_limit = 40 * n_rec + 500;
		repeat (8) @(posedge clk_sys);
		areset <= 1'b0;
		idle_cycles(4);
		for (r = 0; r < n_rec; r++) begin
			arg1  = rec_mem[4*r+1];
			arg2  = rec_mem[4*r+2];
			exp_v = rec_mem[4*r+3];
			case (rec_mem[4*r])
				32'd1: mount_image(arg1, arg2, exp_v);
				32'd2: latch_sector_number(arg1, exp_v);
				32'd3: exercise_buffer(int'(arg1));
				32'd4: issue_request(arg1, exp_v);
				32'd5: send_mouse_packets(arg1, arg2, exp_v);
				32'd6: apply_analog(arg1, exp_v);
				default: abort_run($sformatf("Unknown operation code %0h in record %0d",
					rec_mem[4*r], r));
			endcase
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule
